//--- logic/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width
`define DC_ADDR_W 32

// data word width in bits
`define DC_WORD_W 32

// words per cache line
`define DC_LINE_WORDS 4

// sets per way, kept small so conflicts are easy to build
`define DC_SETS 16

`endif

//--- logic/cacheGeomPkg.sv
`include "dcache_config.svh"

package cacheGeomPkg;

	localparam int BYTE_W = $clog2(`DC_WORD_W / 8);
	localparam int WSEL_W = $clog2(`DC_LINE_WORDS);
	localparam int INDEX_W = $clog2(`DC_SETS);
	localparam int TAG_W = `DC_ADDR_W - INDEX_W - WSEL_W - BYTE_W;

	typedef logic [`DC_ADDR_W-1:0] addrT;
	typedef logic [`DC_WORD_W-1:0] wordT;
	typedef wordT [`DC_LINE_WORDS-1:0] lineT; // word 0 in the low bits
	typedef logic [TAG_W-1:0] tagT;
	typedef logic [INDEX_W-1:0] indexT;
	typedef logic [WSEL_W-1:0] wordSelT;
	typedef logic wayT;

	// address fields, low to high: byte, wordSel, index, tag
	function automatic wordSelT addrWordSel(addrT a);
		return a[BYTE_W +: WSEL_W];
	endfunction

	function automatic indexT addrIndex(addrT a);
		return a[BYTE_W + WSEL_W +: INDEX_W];
	endfunction

	function automatic tagT addrTag(addrT a);
		return a[`DC_ADDR_W-1 -: TAG_W];
	endfunction

	function automatic addrT lineAddr(tagT t, indexT i);
		return {t, i, {(WSEL_W + BYTE_W){1'b0}}};
	endfunction

endpackage

//--- logic/cacheOpPkg.sv
package cacheOpPkg;

	// what the requester sees
	typedef enum logic [1:0] {
		statusIdle,
		statusHit,  // completes this cycle
		statusBusy  // miss or snoop in progress
	} cacheStatusT;

	// miss sequencing
	typedef enum logic [1:0] {
		stIdle,
		stWriteBack,
		stFill
	} missStateT;

endpackage

//--- logic/wayArray.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module wayArray import cacheGeomPkg::*; #(
	parameter type entryT = tagT
) (
	input logic clk,
	input indexT index,
	output entryT rdEntries [2],
	input logic wrEnable,
	input wayT wrWay,
	input entryT wrEntry
);

	entryT mem [2][`DC_SETS];

	// both ways of the set, no clock
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			rdEntries[w] = mem[w][index];
		end
	end

	always_ff @(posedge clk) begin
		if (wrEnable) begin
			mem[wrWay][index] <= wrEntry;
		end
	end

endmodule

//--- logic/tagStore.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module tagStore import cacheGeomPkg::*; (
	input logic clk,
	input logic reset,
	input addrT reqAddr,
	input logic snoopValid,
	input addrT snoopAddr,
	input logic touch,
	input logic install,
	input wayT installWay,
	output logic hit,
	output wayT hitWay,
	output wayT victimWay,
	output tagT victimTag,
	output logic victimDirty,
	input logic markDirty
);

	indexT reqIdx;
	tagT reqTag;
	indexT snoopIdx;
	tagT snoopTag;
	tagT tags [2];
	tagT snoopTags [2][`DC_SETS]; // copy for the snoop port
	logic [1:0][`DC_SETS-1:0] valid;
	logic [1:0][`DC_SETS-1:0] dirty;
	logic [`DC_SETS-1:0] lru; // holds the way to evict next
	logic [1:0] hitVec;
	logic [1:0] snoopMatch;
	logic snoopKillsFill;

	assign reqIdx = addrIndex(reqAddr);
	assign reqTag = addrTag(reqAddr);
	assign snoopIdx = addrIndex(snoopAddr);
	assign snoopTag = addrTag(snoopAddr);

	wayArray #(.entryT(tagT)) tagWays (
		.clk(clk),
		.index(reqIdx),
		.rdEntries(tags),
		.wrEnable(install),
		.wrWay(installWay),
		.wrEntry(reqTag)
	);

	// same writes as tagWays, read at the snoop index
	always_ff @(posedge clk) begin
		if (install) begin
			snoopTags[installWay][reqIdx] <= reqTag;
		end
	end

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hitVec[w] = valid[w][reqIdx] && (tags[w] == reqTag);
			snoopMatch[w] = valid[w][snoopIdx] && (snoopTags[w][snoopIdx] == snoopTag);
		end
	end

	assign hit = (|hitVec) && !snoopValid; // snoop owns the cycle
	assign hitWay = hitVec[1];
	assign victimWay = lru[reqIdx];
	assign victimTag = tags[victimWay];
	assign victimDirty = valid[victimWay][reqIdx] && dirty[victimWay][reqIdx];

	// snoop of the very line being filled, so the fetched copy is stale
	assign snoopKillsFill = snoopValid && (snoopIdx == reqIdx) && (snoopTag == reqTag);

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (snoopValid && snoopMatch[w]) begin
					valid[w][snoopIdx] <= 1'b0;
				end
			end
			if (install) begin
				valid[installWay][reqIdx] <= !snoopKillsFill;
				dirty[installWay][reqIdx] <= 1'b0;
				lru[reqIdx] <= ~installWay;
			end
			if (touch) lru[reqIdx] <= ~hitWay;
			if (markDirty) dirty[hitWay][reqIdx] <= 1'b1;
		end
	end

endmodule

//--- logic/dataStore.sv
`timescale 1ns/1ps

module dataStore import cacheGeomPkg::*; (
	input logic clk,
	input addrT reqAddr,
	input wayT hitWay,
	input wayT victimWay,
	input logic writeWord,
	input wordT writeData,
	input logic install,
	input wayT installWay,
	input lineT fillLine,
	output wordT readData,
	output lineT victimLine
);

	indexT reqIdx;
	wordSelT wordSel;
	lineT lines [2];
	lineT merged;
	logic wrEnable;
	wayT wrWay;
	lineT wrEntry;

	assign reqIdx = addrIndex(reqAddr);
	assign wordSel = addrWordSel(reqAddr);

	wayArray #(.entryT(lineT)) lineWays (
		.clk(clk),
		.index(reqIdx),
		.rdEntries(lines),
		.wrEnable(wrEnable),
		.wrWay(wrWay),
		.wrEntry(wrEntry)
	);

	assign readData = lines[hitWay][wordSel];
	assign victimLine = lines[victimWay]; // whole line for write-back

	// hit line with one word replaced
	always_comb begin
		merged = lines[hitWay];
		merged[wordSel] = writeData;
	end

	// install and writeWord never coincide
	assign wrEnable = writeWord || install;
	assign wrWay = install ? installWay : hitWay;
	assign wrEntry = install ? fillLine : merged;

endmodule

//--- logic/missController.sv
`timescale 1ns/1ps

module missController import cacheGeomPkg::*, cacheOpPkg::*; (
	input logic clk,
	input logic reset,
	input logic reqEnable,
	input logic reqWrite,
	input addrT reqAddr,
	input logic snoopValid,
	input logic hit,
	input wayT victimWay,
	input tagT victimTag,
	input logic victimDirty,
	input lineT victimLine,
	output logic memReadReq,
	output logic memWriteReq,
	output addrT memAddr,
	output lineT memWriteLine,
	input logic memReadDone,
	input logic memWriteDone,
	output logic install,
	output wayT installWay,
	output cacheStatusT status,
	output logic touch,
	output logic writeWord,
	output logic markDirty
);

	missStateT state;
	addrT fillAddr;
	logic miss;

	// a snoop cycle never starts a miss
	assign miss = reqEnable && !hit && !snoopValid;

	always_comb begin
		if (snoopValid) begin
			status = statusBusy;
		end else if (!reqEnable) begin
			status = statusIdle;
		end else if (hit && state == stIdle) begin
			status = statusHit;
		end else begin
			status = statusBusy;
		end
	end

	assign touch = (status == statusHit);
	assign writeWord = touch && reqWrite;
	assign markDirty = writeWord;

	assign install = (state == stFill) && memReadDone;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			memReadReq <= 1'b0;
			memWriteReq <= 1'b0;
		end else begin
			memReadReq <= 1'b0; // strobes last one cycle
			memWriteReq <= 1'b0;
			case (state)
				stIdle: begin
					if (miss) begin
						if (victimDirty) begin
							memWriteReq <= 1'b1;
							state <= stWriteBack;
						end else begin
							memReadReq <= 1'b1;
							state <= stFill;
						end
					end
				end
				stWriteBack: begin
					if (memWriteDone) begin
						memReadReq <= 1'b1;
						state <= stFill;
					end
				end
				stFill: begin
					if (memReadDone) state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

	// miss payload
	always_ff @(posedge clk) begin
		if (state == stIdle && miss) begin
			installWay <= victimWay;
			fillAddr <= lineAddr(addrTag(reqAddr), addrIndex(reqAddr));
			memWriteLine <= victimLine;
			if (victimDirty) begin
				memAddr <= lineAddr(victimTag, addrIndex(reqAddr));
			end else begin
				memAddr <= lineAddr(addrTag(reqAddr), addrIndex(reqAddr));
			end
		end else if (state == stWriteBack && memWriteDone) begin
			memAddr <= fillAddr;
		end
	end

endmodule

//--- logic/dCacheTop.sv
`timescale 1ns/1ps

module dCacheTop import cacheGeomPkg::*, cacheOpPkg::*; (
	input logic clk,
	input logic reset,
	input logic reqEnable,
	input logic reqWrite,
	input addrT reqAddr,
	input wordT writeData,
	output cacheStatusT status,
	output wordT readData,
	output logic memReadReq,
	output logic memWriteReq,
	output addrT memAddr,
	output lineT memWriteLine,
	input logic memReadDone,
	input logic memWriteDone,
	input lineT memReadLine,
	input logic snoopValid,
	input addrT snoopAddr
);

	logic hit;
	wayT hitWay;
	wayT victimWay;
	tagT victimTag;
	logic victimDirty;
	lineT victimLine;
	logic install;
	wayT installWay;
	logic touch;
	logic writeWord;
	logic markDirty;

	tagStore tagStore_i (
		.clk(clk),
		.reset(reset),
		.reqAddr(reqAddr),
		.snoopValid(snoopValid),
		.snoopAddr(snoopAddr),
		.touch(touch),
		.install(install),
		.installWay(installWay),
		.hit(hit),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimTag(victimTag),
		.victimDirty(victimDirty),
		.markDirty(markDirty)
	);

	dataStore dataStore_i (
		.clk(clk),
		.reqAddr(reqAddr),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.writeWord(writeWord),
		.writeData(writeData),
		.install(install),
		.installWay(installWay),
		.fillLine(memReadLine), // fill goes straight in
		.readData(readData),
		.victimLine(victimLine)
	);

	missController missController_i (
		.clk(clk),
		.reset(reset),
		.reqEnable(reqEnable),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.snoopValid(snoopValid),
		.hit(hit),
		.victimWay(victimWay),
		.victimTag(victimTag),
		.victimDirty(victimDirty),
		.victimLine(victimLine),
		.memReadReq(memReadReq),
		.memWriteReq(memWriteReq),
		.memAddr(memAddr),
		.memWriteLine(memWriteLine),
		.memReadDone(memReadDone),
		.memWriteDone(memWriteDone),
		.install(install),
		.installWay(installWay),
		.status(status),
		.touch(touch),
		.writeWord(writeWord),
		.markDirty(markDirty)
	);

endmodule

//--- sim/dCache_assert.sv
`timescale 1ns/1ps

module dCache_assert import cacheOpPkg::*; (
	input logic clk,
	input logic reset,
	input logic snoopValid,
	input cacheStatusT status,
	input logic memReadReq,
	input logic memWriteReq
);

	// one transfer at a time toward memory
	strobeExclusive: assert property (
		@(posedge clk) disable iff (reset) !(memReadReq && memWriteReq)
	) else $error("memReadReq and memWriteReq high in the same cycle");

	readStrobePulse: assert property (
		@(posedge clk) disable iff (reset) memReadReq |=> !memReadReq
	) else $error("memReadReq held high for two cycles");

	writeStrobePulse: assert property (
		@(posedge clk) disable iff (reset) memWriteReq |=> !memWriteReq
	) else $error("memWriteReq held high for two cycles");

	// snoop owns the cycle
	snoopBlocksHit: assert property (
		@(posedge clk) disable iff (reset) snoopValid |-> status != statusHit
	) else $error("status reported hit during a snoop cycle");

endmodule

//--- sim/dCacheTb.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dCacheTb import cacheGeomPkg::*, cacheOpPkg::*;;

	localparam int OP_WORST = 16; // write-back, fill and hit of one request
	localparam int OP_COUNT = 220;
	localparam int TIMEOUT_CYCLES = 2 * (OP_COUNT * OP_WORST + 8);

	logic clk = 1'b0;
	logic reset;
	logic reqEnable;
	logic reqWrite;
	addrT reqAddr;
	wordT writeData;
	cacheStatusT status;
	wordT readData;
	logic memReadReq;
	logic memWriteReq;
	addrT memAddr;
	lineT memWriteLine;
	logic memReadDone = 1'b0;
	logic memWriteDone = 1'b0;
	lineT memReadLine = '0;
	logic snoopValid;
	addrT snoopAddr;

	lineT mem [addrT]; // backing memory, keyed by line address
	wordT shadow [addrT];
	int readReqCount = 0;
	int writeReqCount = 0;
	int readDelay = 0;
	int writeDelay = 0;
	addrT lastReadAddr = '0;
	addrT lastWriteAddr = '0;
	lineT lastWriteLine = '0;
	int valueErrors = 0;
	int countErrors = 0;
	int cycleCount = 0;

	dCacheTop dCacheTop_i (
		.clk(clk),
		.reset(reset),
		.reqEnable(reqEnable),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.writeData(writeData),
		.status(status),
		.readData(readData),
		.memReadReq(memReadReq),
		.memWriteReq(memWriteReq),
		.memAddr(memAddr),
		.memWriteLine(memWriteLine),
		.memReadDone(memReadDone),
		.memWriteDone(memWriteDone),
		.memReadLine(memReadLine),
		.snoopValid(snoopValid),
		.snoopAddr(snoopAddr)
	);

	bind dCacheTop dCache_assert dCache_assert_i (
		.clk(clk),
		.reset(reset),
		.snoopValid(snoopValid),
		.status(status),
		.memReadReq(memReadReq),
		.memWriteReq(memWriteReq)
	);

	always #2 clk = ~clk;

	// fields low to high: 2 byte bits, wordSel, index, tag
	function automatic addrT addrOf(int tag, int set, int word);
		return addrT'(tag) << 8 | addrT'(set) << 4 | addrT'(word) << 2;
	endfunction

	function automatic wordT patternWord(addrT a);
		return ~wordT'(a & ~addrT'(3)); // inverted byte address
	endfunction

	function automatic lineT modelLine(addrT a);
		lineT l;
		if (mem.exists(a)) begin
			return mem[a];
		end
		for (int w = 0; w < `DC_LINE_WORDS; w++) begin
			l[w] = patternWord(a + addrT'(4 * w));
		end
		return l;
	endfunction

	// samples strobes mid-cycle, answers 3 cycles later
	always begin
		@(negedge clk);
		if (!reset && memReadReq) begin
			readReqCount++;
			lastReadAddr = memAddr;
			readDelay = 3;
		end
		if (!reset && memWriteReq) begin
			writeReqCount++;
			lastWriteAddr = memAddr;
			lastWriteLine = memWriteLine;
			mem[memAddr] = memWriteLine;
			writeDelay = 3;
		end
		@(posedge clk);
		#1;
		memReadDone = 1'b0;
		memWriteDone = 1'b0;
		if (readDelay > 0) begin
			readDelay--;
			if (readDelay == 0) begin
				memReadDone = 1'b1;
				memReadLine = modelLine(lastReadAddr);
			end
		end
		if (writeDelay > 0) begin
			writeDelay--;
			if (writeDelay == 0) memWriteDone = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic checkWord(input string msg, input wordT got, input wordT exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERR %0t %s: got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic checkAddr(input string msg, input addrT got, input addrT exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERR %0t %s: got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic checkStatus(input string msg, input cacheStatusT got, input cacheStatusT exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERR %0t %s: got %s, expected %s", $time, msg, got.name(), exp.name());
		end
	endtask

	task automatic checkCount(input string msg, input int got, input int exp);
		if (got != exp) begin
			countErrors++;
			$display("ERR %0t %s: got %0d strobes, expected %0d", $time, msg, got, exp);
		end
	endtask

	// called just after a rising edge, returns just after the commit edge
	task automatic doRead(input addrT a, output wordT data);
		reqEnable = 1'b1;
		reqWrite = 1'b0;
		reqAddr = a;
		@(negedge clk);
		while (status != statusHit) @(negedge clk);
		data = readData;
		@(posedge clk);
		#1;
		reqEnable = 1'b0;
	endtask

	task automatic doWrite(input addrT a, input wordT d);
		reqEnable = 1'b1;
		reqWrite = 1'b1;
		reqAddr = a;
		writeData = d;
		@(negedge clk);
		while (status != statusHit) @(negedge clk);
		@(posedge clk);
		#1;
		reqEnable = 1'b0;
		reqWrite = 1'b0;
	endtask

	// snoop lands in the first cycle of a read of the same line, read stays held
	task automatic doSnoop(input addrT a);
		reqEnable = 1'b1;
		reqWrite = 1'b0;
		reqAddr = a;
		snoopValid = 1'b1;
		snoopAddr = a;
		@(negedge clk);
		checkStatus("snoop cycle status", status, statusBusy);
		@(posedge clk);
		#1;
		snoopValid = 1'b0;
	endtask

	task automatic readExpect(input addrT a, input wordT exp, input string msg);
		wordT got;
		doRead(a, got);
		checkWord(msg, got, exp);
	endtask

	task automatic coldReadMiss();
		addrT a;
		int reads;
		a = addrOf(16, 0, 1);
		reads = readReqCount;
		readExpect(a, patternWord(a), "cold miss data");
		checkCount("cold miss fills", readReqCount - reads, 1);
		checkAddr("cold miss fill address", lastReadAddr, addrOf(16, 0, 0));
	endtask

	task automatic writeThenRead();
		addrT a;
		int strobes;
		a = addrOf(16, 0, 2);
		strobes = readReqCount + writeReqCount;
		doWrite(a, 32'hdead_beef);
		readExpect(a, 32'hdead_beef, "write hit readback");
		checkCount("write hit strobes", readReqCount + writeReqCount - strobes, 0);
	endtask

	task automatic lruReplacement();
		addrT a;
		addrT b;
		addrT c;
		int reads;
		a = addrOf(1, 2, 0);
		b = addrOf(2, 2, 1);
		c = addrOf(3, 2, 2);
		readExpect(a, patternWord(a), "lru fill A");
		readExpect(b, patternWord(b), "lru fill B");
		readExpect(a, patternWord(a), "lru touch A");
		readExpect(c, patternWord(c), "lru fill C"); // B is least recent
		reads = readReqCount;
		readExpect(a, patternWord(a), "lru A kept");
		checkCount("lru A still resident", readReqCount - reads, 0);
		readExpect(b, patternWord(b), "lru B refetched");
		checkCount("lru B evicted", readReqCount - reads, 1);
		checkAddr("lru B fill address", lastReadAddr, addrOf(2, 2, 0));
	endtask

	task automatic dirtyWriteBack();
		addrT a;
		addrT b;
		addrT c;
		int writes;
		a = addrOf(1, 3, 1);
		b = addrOf(2, 3, 0);
		c = addrOf(3, 3, 0);
		doWrite(a, 32'h1234_5678);
		readExpect(b, patternWord(b), "conflict fill B");
		writes = writeReqCount;
		readExpect(c, patternWord(c), "conflict fill C");
		checkCount("dirty eviction write-backs", writeReqCount - writes, 1);
		checkAddr("write-back address", lastWriteAddr, addrOf(1, 3, 0));
		checkWord("written-back word", lastWriteLine[1], 32'h1234_5678);
		checkWord("written-back clean word", lastWriteLine[0], patternWord(addrOf(1, 3, 0)));
		readExpect(a, 32'h1234_5678, "reread after write-back");
	endtask

	task automatic snoopInvalidate();
		addrT a;
		int reads;
		a = addrOf(5, 4, 3);
		readExpect(a, patternWord(a), "snoop line fill");
		reads = readReqCount;
		readExpect(a, patternWord(a), "hit before snoop");
		checkCount("hit before snoop", readReqCount - reads, 0);
		doSnoop(a);
		readExpect(a, patternWord(a), "read after snoop");
		checkCount("refetch after snoop", readReqCount - reads, 1);
	endtask

	task automatic randomMix();
		addrT a;
		wordT d;
		wordT got;
		wordT exp;
		for (int i = 0; i < 200; i++) begin
			a = addrOf(16 + int'($urandom % 6), 5 + int'($urandom % 3), int'($urandom % 4));
			if ($urandom % 2 == 0) begin
				d = $urandom;
				doWrite(a, d);
				shadow[a] = d;
			end else begin
				exp = shadow.exists(a) ? shadow[a] : patternWord(a);
				doRead(a, got);
				checkWord($sformatf("random read at %h", a), got, exp);
			end
		end
	endtask

	initial begin
		void'($urandom(48));
		reset = 1'b1;
		reqEnable = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		writeData = '0;
		snoopValid = 1'b0;
		snoopAddr = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		checkStatus("status after reset", status, statusIdle);
		@(posedge clk);
		#1;
		coldReadMiss();
		writeThenRead();
		lruReplacement();
		dirtyWriteBack();
		snoopInvalidate();
		randomMix();
		$display("errors: %0d value mismatches, %0d strobe count mismatches",
			valueErrors, countErrors);
		if (valueErrors + countErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- dCacheTop.f
+incdir+logic
logic/cacheGeomPkg.sv
logic/cacheOpPkg.sv
logic/wayArray.sv
logic/tagStore.sv
logic/dataStore.sv
logic/missController.sv
logic/dCacheTop.sv
sim/dCache_assert.sv
sim/dCacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the data cache testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dCacheTb -f dCacheTop.f

./obj_dir/VdCacheTb 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run failed, see sim.log"
	exit 1
fi

echo "run finished without failure"
